// File: hdl/dma_bus_pkg.sv
`default_nettype none

// memory side of the controller: stream engines, arbiter and memory port
package dma_bus_pkg;

localparam int NUM_STREAMS = 4;
localparam int STREAM_W    = 2;

// byte addressed, word wide
localparam int ADDR_W = 32;
localparam int DATA_W = 32;

// remaining-items counter
localparam int CNT_W = 16;

// one item is one 32-bit word
localparam logic [ADDR_W-1:0] ADDR_STEP = 4;

// bus priority level, 3 wins
typedef logic [1:0] prio_t;

endpackage

`default_nettype wire

// File: hdl/dma_reg_pkg.sv
`default_nettype none

// host view of the controller: register map and control word layout
package dma_reg_pkg;

localparam int REG_AW = 8;

// each stream owns one 16-byte block starting at 0x00
localparam int STREAM_STRIDE = 16;

localparam logic [3:0] OFF_CR   = 4'd0;
localparam logic [3:0] OFF_NDTR = 4'd4;
localparam logic [3:0] OFF_SAR  = 4'd8;
localparam logic [3:0] OFF_DAR  = 4'd12;

// shared status, one TCIF bit per stream
localparam logic [REG_AW-1:0] ADDR_ISR  = 8'h40;
localparam logic [REG_AW-1:0] ADDR_IFCR = 8'h44;

typedef struct packed {
    logic [25:0] rsvd;
    logic [1:0]  pl;
    logic        dinc;
    logic        sinc;
    logic        tcie;
    logic        en;
} cr_fields_t;

// host moves the raw word, the logic looks at the fields
typedef union packed {
    logic [31:0] raw;
    cr_fields_t  f;
} cr_word_u;

endpackage

`default_nettype wire

// File: hdl/dma_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
    input  logic                                                  i_hclk,
    input  logic                                                  i_rst_n,

    // host port
    input  logic                                                  i_reg_req,
    input  logic                                                  i_reg_write,
    input  logic [dma_reg_pkg::REG_AW-1:0]                        i_reg_addr,
    input  logic [dma_bus_pkg::DATA_W-1:0]                        i_reg_wdata,
    output logic                                                  o_reg_ack,
    output logic [dma_bus_pkg::DATA_W-1:0]                        o_reg_rdata,

    // per stream configuration
    output logic [dma_bus_pkg::NUM_STREAMS-1:0]                   o_start,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::ADDR_W-1:0] o_sar,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::ADDR_W-1:0] o_dar,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::CNT_W-1:0]  o_ndtr,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0]                   o_sinc,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0]                   o_dinc,
    output dma_bus_pkg::prio_t [dma_bus_pkg::NUM_STREAMS-1:0]     o_prio,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::CNT_W-1:0]  i_count,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0]                   i_done,

    output logic [dma_bus_pkg::NUM_STREAMS-1:0]                   o_interrupt
);

dma_reg_pkg::cr_word_u [dma_bus_pkg::NUM_STREAMS-1:0] cr_q;
dma_reg_pkg::cr_word_u                                cr_wr;
logic [dma_bus_pkg::NUM_STREAMS-1:0]                  tcif_q;
logic [dma_bus_pkg::NUM_STREAMS-1:0]                  tcie;
logic [dma_bus_pkg::STREAM_W-1:0]                     sel_stream;
logic [$clog2(dma_reg_pkg::STREAM_STRIDE)-1:0]        sel_off;
logic                                                 in_blk;
logic                                                 access;
logic                                                 wr_cfg;
logic [dma_bus_pkg::DATA_W-1:0]                       rd_data;

// new access only while ack is low
assign access     = i_reg_req && !o_reg_ack;
assign sel_off    = i_reg_addr[$clog2(dma_reg_pkg::STREAM_STRIDE)-1:0];
assign sel_stream = i_reg_addr[$clog2(dma_reg_pkg::STREAM_STRIDE) +: dma_bus_pkg::STREAM_W];
assign in_blk     = (i_reg_addr[dma_reg_pkg::REG_AW-1:
                     $clog2(dma_reg_pkg::STREAM_STRIDE)+dma_bus_pkg::STREAM_W] == '0);

// address and count are locked while the stream runs
assign wr_cfg = access && i_reg_write && in_blk && !cr_q[sel_stream].f.en;

always_comb begin
    cr_wr.raw    = i_reg_wdata;
    cr_wr.f.rsvd = '0;
end

always_comb begin
    for (int s = 0; s < dma_bus_pkg::NUM_STREAMS; s++) begin
        o_sinc[s] = cr_q[s].f.sinc;
        o_dinc[s] = cr_q[s].f.dinc;
        o_prio[s] = cr_q[s].f.pl;
        tcie[s]   = cr_q[s].f.tcie;
    end
end

always_comb begin
    rd_data = '0;
    if (in_blk) begin
        case (sel_off)
            dma_reg_pkg::OFF_CR:   rd_data = cr_q[sel_stream].raw;
            dma_reg_pkg::OFF_NDTR: rd_data[dma_bus_pkg::CNT_W-1:0] =
                cr_q[sel_stream].f.en ? i_count[sel_stream] : o_ndtr[sel_stream];
            dma_reg_pkg::OFF_SAR:  rd_data = o_sar[sel_stream];
            dma_reg_pkg::OFF_DAR:  rd_data = o_dar[sel_stream];
            default:               rd_data = '0;
        endcase
    end else if (i_reg_addr == dma_reg_pkg::ADDR_ISR) begin
        rd_data[dma_bus_pkg::NUM_STREAMS-1:0] = tcif_q;
    end
end

always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_reg_ack   <= 1'b0;
        o_start     <= '0;
        cr_q        <= '0;
        tcif_q      <= '0;
        o_interrupt <= '0;
    end else begin
        o_start <= '0;
        if (!o_reg_ack) begin
            o_reg_ack <= i_reg_req;
        end else if (!i_reg_req) begin
            o_reg_ack <= 1'b0;
        end

        if (access && i_reg_write && in_blk && sel_off == dma_reg_pkg::OFF_CR) begin
            cr_q[sel_stream] <= cr_wr;
            // rising en kicks the engine
            if (cr_wr.f.en && !cr_q[sel_stream].f.en) begin
                o_start[sel_stream] <= 1'b1;
            end
        end
        if (access && i_reg_write && i_reg_addr == dma_reg_pkg::ADDR_IFCR) begin
            tcif_q <= tcif_q & ~i_reg_wdata[dma_bus_pkg::NUM_STREAMS-1:0];
        end

        // completion wins over a clear in the same cycle
        for (int s = 0; s < dma_bus_pkg::NUM_STREAMS; s++) begin
            if (i_done[s]) begin
                cr_q[s].f.en <= 1'b0;
                tcif_q[s]    <= 1'b1;
            end
        end

        o_interrupt <= tcif_q & tcie;
    end
end

always_ff @(posedge i_hclk) begin
    if (access && !i_reg_write) begin
        o_reg_rdata <= rd_data;
    end
    if (wr_cfg) begin
        case (sel_off)
            dma_reg_pkg::OFF_NDTR: o_ndtr[sel_stream] <= i_reg_wdata[dma_bus_pkg::CNT_W-1:0];
            dma_reg_pkg::OFF_SAR:  o_sar[sel_stream]  <= i_reg_wdata;
            dma_reg_pkg::OFF_DAR:  o_dar[sel_stream]  <= i_reg_wdata;
            default: ;
        endcase
    end
    // ndtr follows the engine count once the transfer ends
    for (int s = 0; s < dma_bus_pkg::NUM_STREAMS; s++) begin
        if (i_done[s]) begin
            o_ndtr[s] <= i_count[s];
        end
    end
end

a_ack_needs_req: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    $rose(o_reg_ack) |-> $past(i_reg_req));

endmodule

`default_nettype wire

// File: hdl/dma_stream.sv
`timescale 1ns/1ps
`default_nettype none

module dma_stream (
    input  logic                            i_hclk,
    input  logic                            i_rst_n,

    // configuration from the register block
    input  logic                            i_start,
    input  logic [dma_bus_pkg::ADDR_W-1:0]  i_sar,
    input  logic [dma_bus_pkg::ADDR_W-1:0]  i_dar,
    input  logic [dma_bus_pkg::CNT_W-1:0]   i_ndtr,
    input  logic                            i_sinc,
    input  logic                            i_dinc,

    // beat request towards the arbiter
    output logic                            o_bus_req,
    output logic                            o_bus_write,
    output logic [dma_bus_pkg::ADDR_W-1:0]  o_bus_addr,
    output logic [dma_bus_pkg::DATA_W-1:0]  o_bus_wdata,
    input  logic                            i_bus_done,
    input  logic [dma_bus_pkg::DATA_W-1:0]  i_bus_rdata,

    output logic [dma_bus_pkg::CNT_W-1:0]   o_count,
    output logic                            o_done
);

logic                           busy_q;
logic                           wr_phase_q;
logic [dma_bus_pkg::CNT_W-1:0]  cnt_q;
logic [dma_bus_pkg::CNT_W-1:0]  cnt_next;
logic [dma_bus_pkg::ADDR_W-1:0] src_q;
logic [dma_bus_pkg::ADDR_W-1:0] dst_q;
logic [dma_bus_pkg::DATA_W-1:0] data_q;
logic                           load;
logic                           beat_end;

// a start during a running copy is dropped
assign load     = i_start && !busy_q;
assign beat_end = busy_q && i_bus_done;
assign cnt_next = cnt_q - 1'b1;

always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        busy_q     <= 1'b0;
        wr_phase_q <= 1'b0;
        cnt_q      <= '0;
        o_done     <= 1'b0;
    end else begin
        o_done <= 1'b0;
        if (load) begin
            cnt_q      <= i_ndtr;
            wr_phase_q <= 1'b0;
            if (i_ndtr == '0) begin
                o_done <= 1'b1;
            end else begin
                busy_q <= 1'b1;
            end
        end else if (beat_end) begin
            if (!wr_phase_q) begin
                wr_phase_q <= 1'b1;
            end else begin
                // item complete
                wr_phase_q <= 1'b0;
                cnt_q      <= cnt_next;
                if (cnt_next == '0) begin
                    busy_q <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end
end

always_ff @(posedge i_hclk) begin
    if (load) begin
        src_q <= i_sar;
        dst_q <= i_dar;
    end else if (beat_end) begin
        if (!wr_phase_q) begin
            data_q <= i_bus_rdata;
        end else begin
            src_q <= src_q + (i_sinc ? dma_bus_pkg::ADDR_STEP : '0);
            dst_q <= dst_q + (i_dinc ? dma_bus_pkg::ADDR_STEP : '0);
        end
    end
end

assign o_bus_req   = busy_q;
assign o_bus_write = wr_phase_q;
assign o_bus_addr  = wr_phase_q ? dst_q : src_q;
assign o_bus_wdata = data_q;
assign o_count     = cnt_q;

// beat is held with a steady address until the arbiter finishes it
a_req_held: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    o_bus_req && !i_bus_done |=> o_bus_req && $stable(o_bus_addr));

endmodule

`default_nettype wire

// File: hdl/dma_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dma_bus_arbiter (
    input  logic                                                          i_hclk,
    input  logic                                                          i_rst_n,

    // stream side
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0]                           i_bus_req,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0]                           i_bus_write,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::ADDR_W-1:0]  i_bus_addr,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::DATA_W-1:0]  i_bus_wdata,
    input  dma_bus_pkg::prio_t [dma_bus_pkg::NUM_STREAMS-1:0]             i_prio,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0]                           o_bus_done,
    output logic [dma_bus_pkg::DATA_W-1:0]                                o_bus_rdata,

    // memory port
    output logic                                                          o_mem_req,
    output logic                                                          o_mem_write,
    output logic [dma_bus_pkg::ADDR_W-1:0]                                o_mem_addr,
    output logic [dma_bus_pkg::DATA_W-1:0]                                o_mem_wdata,
    input  logic                                                          i_mem_ack,
    input  logic [dma_bus_pkg::DATA_W-1:0]                                i_mem_rdata
);

logic [dma_bus_pkg::NUM_STREAMS-1:0] grant_q;
logic                                win_valid;
logic [dma_bus_pkg::STREAM_W-1:0]    win_idx;
dma_bus_pkg::prio_t                  win_prio;
logic                                bus_idle;
logic                                launch;

// wait for ack low and for the finished stream to see its done
assign bus_idle = !o_mem_req && !i_mem_ack && (o_bus_done == '0);
assign launch   = bus_idle && win_valid;

// walk down so that equal levels settle on the lowest index
always_comb begin
    win_valid = 1'b0;
    win_idx   = '0;
    win_prio  = '0;
    for (int i = dma_bus_pkg::NUM_STREAMS - 1; i >= 0; i--) begin
        if (i_bus_req[i] && (!win_valid || i_prio[i] >= win_prio)) begin
            win_valid = 1'b1;
            win_idx   = i[dma_bus_pkg::STREAM_W-1:0];
            win_prio  = i_prio[i];
        end
    end
end

always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_mem_req  <= 1'b0;
        grant_q    <= '0;
        o_bus_done <= '0;
    end else begin
        o_bus_done <= '0;
        if (o_mem_req) begin
            if (i_mem_ack) begin
                // grant lasts a single beat
                o_mem_req  <= 1'b0;
                o_bus_done <= grant_q;
                grant_q    <= '0;
            end
        end else if (launch) begin
            o_mem_req        <= 1'b1;
            grant_q          <= '0;
            grant_q[win_idx] <= 1'b1;
        end
    end
end

always_ff @(posedge i_hclk) begin
    if (launch) begin
        o_mem_write <= i_bus_write[win_idx];
        o_mem_addr  <= i_bus_addr[win_idx];
        o_mem_wdata <= i_bus_wdata[win_idx];
    end
    if (o_mem_req && i_mem_ack) begin
        o_bus_rdata <= i_mem_rdata;
    end
end

a_grant_onehot: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    $onehot0(grant_q));

a_addr_stable: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    o_mem_req && !i_mem_ack |=> $stable(o_mem_addr));

endmodule

`default_nettype wire

// File: hdl/dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top (
    input  logic                                i_hclk,
    input  logic                                i_rst_n,

    // host port
    input  logic                                i_reg_req,
    input  logic                                i_reg_write,
    input  logic [dma_reg_pkg::REG_AW-1:0]      i_reg_addr,
    input  logic [dma_bus_pkg::DATA_W-1:0]      i_reg_wdata,
    output logic                                o_reg_ack,
    output logic [dma_bus_pkg::DATA_W-1:0]      o_reg_rdata,

    // memory port
    output logic                                o_mem_req,
    output logic                                o_mem_write,
    output logic [dma_bus_pkg::ADDR_W-1:0]      o_mem_addr,
    output logic [dma_bus_pkg::DATA_W-1:0]      o_mem_wdata,
    input  logic                                i_mem_ack,
    input  logic [dma_bus_pkg::DATA_W-1:0]      i_mem_rdata,

    output logic [dma_bus_pkg::NUM_STREAMS-1:0] o_interrupt
);

genvar st;

logic [dma_bus_pkg::NUM_STREAMS-1:0]                          start;
logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::ADDR_W-1:0] sar;
logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::ADDR_W-1:0] dar;
logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::CNT_W-1:0]  ndtr;
logic [dma_bus_pkg::NUM_STREAMS-1:0]                          sinc;
logic [dma_bus_pkg::NUM_STREAMS-1:0]                          dinc;
dma_bus_pkg::prio_t [dma_bus_pkg::NUM_STREAMS-1:0]            prio;
logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::CNT_W-1:0]  count;
logic [dma_bus_pkg::NUM_STREAMS-1:0]                          done;

// stream to arbiter
logic [dma_bus_pkg::NUM_STREAMS-1:0]                          bus_req;
logic [dma_bus_pkg::NUM_STREAMS-1:0]                          bus_write;
logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::ADDR_W-1:0] bus_addr;
logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_bus_pkg::DATA_W-1:0] bus_wdata;
logic [dma_bus_pkg::NUM_STREAMS-1:0]                          bus_done;
logic [dma_bus_pkg::DATA_W-1:0]                               bus_rdata;

dma_regs dma_regs (
    .i_hclk(i_hclk),
    .i_rst_n(i_rst_n),
    .i_reg_req(i_reg_req),
    .i_reg_write(i_reg_write),
    .i_reg_addr(i_reg_addr),
    .i_reg_wdata(i_reg_wdata),
    .o_reg_ack(o_reg_ack),
    .o_reg_rdata(o_reg_rdata),
    .o_start(start),
    .o_sar(sar),
    .o_dar(dar),
    .o_ndtr(ndtr),
    .o_sinc(sinc),
    .o_dinc(dinc),
    .o_prio(prio),
    .i_count(count),
    .i_done(done),
    .o_interrupt(o_interrupt)
);

generate
    for (st = 0; st < dma_bus_pkg::NUM_STREAMS; ++st) begin: g_stream
        dma_stream dma_stream (
            .i_hclk(i_hclk),
            .i_rst_n(i_rst_n),
            .i_start(start[st]),
            .i_sar(sar[st]),
            .i_dar(dar[st]),
            .i_ndtr(ndtr[st]),
            .i_sinc(sinc[st]),
            .i_dinc(dinc[st]),
            .o_bus_req(bus_req[st]),
            .o_bus_write(bus_write[st]),
            .o_bus_addr(bus_addr[st]),
            .o_bus_wdata(bus_wdata[st]),
            .i_bus_done(bus_done[st]),
            .i_bus_rdata(bus_rdata),
            .o_count(count[st]),
            .o_done(done[st])
        );
    end
endgenerate

// read data is shared, only the done pulse is per stream
dma_bus_arbiter dma_bus_arbiter (
    .i_hclk(i_hclk),
    .i_rst_n(i_rst_n),
    .i_bus_req(bus_req),
    .i_bus_write(bus_write),
    .i_bus_addr(bus_addr),
    .i_bus_wdata(bus_wdata),
    .i_prio(prio),
    .o_bus_done(bus_done),
    .o_bus_rdata(bus_rdata),
    .o_mem_req(o_mem_req),
    .o_mem_write(o_mem_write),
    .o_mem_addr(o_mem_addr),
    .o_mem_wdata(o_mem_wdata),
    .i_mem_ack(i_mem_ack),
    .i_mem_rdata(i_mem_rdata)
);

endmodule

`default_nettype wire

// File: sim/tb_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_top;

localparam int STIM_OPS   = 128;
localparam int STIM_WORDS = 3 * STIM_OPS;

logic                                i_hclk;
logic                                i_rst_n;
logic                                i_reg_req;
logic                                i_reg_write;
logic [dma_reg_pkg::REG_AW-1:0]      i_reg_addr;
logic [dma_bus_pkg::DATA_W-1:0]      i_reg_wdata;
logic                                o_reg_ack;
logic [dma_bus_pkg::DATA_W-1:0]      o_reg_rdata;
logic                                o_mem_req;
logic                                o_mem_write;
logic [dma_bus_pkg::ADDR_W-1:0]      o_mem_addr;
logic [dma_bus_pkg::DATA_W-1:0]      o_mem_wdata;
logic                                i_mem_ack;
logic [dma_bus_pkg::DATA_W-1:0]      i_mem_rdata;
logic [dma_bus_pkg::NUM_STREAMS-1:0] o_interrupt;

logic [31:0] stim [0:STIM_WORDS-1];
logic [31:0] mem [logic [31:0]];
logic [31:0] lcg_state;
int          mem_wait;
bit          mem_armed;
int          checks;
int          errors;
int          cycles;
int          cycle_limit;

dma_top DUT (
    .i_hclk(i_hclk),
    .i_rst_n(i_rst_n),
    .i_reg_req(i_reg_req),
    .i_reg_write(i_reg_write),
    .i_reg_addr(i_reg_addr),
    .i_reg_wdata(i_reg_wdata),
    .o_reg_ack(o_reg_ack),
    .o_reg_rdata(o_reg_rdata),
    .o_mem_req(o_mem_req),
    .o_mem_write(o_mem_write),
    .o_mem_addr(o_mem_addr),
    .o_mem_wdata(o_mem_wdata),
    .i_mem_ack(i_mem_ack),
    .i_mem_rdata(i_mem_rdata),
    .o_interrupt(o_interrupt)
);

initial i_hclk = 1'b0;
always #50 i_hclk = ~i_hclk;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// words never written read back as a pattern of their own address
function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem.exists(addr)) begin
        return mem[addr];
    end
    return addr ^ 32'hA5A5_5A5A;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

task automatic host_access(input logic write, input logic [7:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge i_hclk);
    i_reg_req   <= 1'b1;
    i_reg_write <= write;
    i_reg_addr  <= addr;
    i_reg_wdata <= wdata;
    do begin
        @(posedge i_hclk);
    end while (!o_reg_ack);
    rdata = o_reg_rdata;
    i_reg_req <= 1'b0;
    do begin
        @(posedge i_hclk);
    end while (o_reg_ack);
endtask

task automatic wait_interrupt(input logic [1:0] stream);
    do begin
        @(posedge i_hclk);
    end while (!o_interrupt[stream]);
endtask

// memory slave, ack after 0 to 3 idle cycles
always @(posedge i_hclk) begin
    if (!i_rst_n) begin
        i_mem_ack <= 1'b0;
        mem_armed = 1'b0;
    end else if (i_mem_ack) begin
        if (!o_mem_req) begin
            i_mem_ack <= 1'b0;
        end
    end else if (o_mem_req) begin
        if (!mem_armed) begin
            mem_wait  = lcg_next() >> 30;
            mem_armed = 1'b1;
        end
        if (mem_wait == 0) begin
            if (o_mem_write) begin
                mem[o_mem_addr] = o_mem_wdata;
            end else begin
                i_mem_rdata <= mem_read(o_mem_addr);
            end
            i_mem_ack <= 1'b1;
            mem_armed = 1'b0;
        end else begin
            mem_wait = mem_wait - 1;
        end
    end
end

always @(posedge i_hclk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
        errors++;
        $display("simulation timed out after %0d cycles", cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    end
end

initial begin
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    int          items;
    int          idx;
    bit          running;

    i_rst_n     = 1'b0;
    i_reg_req   = 1'b0;
    i_reg_write = 1'b0;
    i_reg_addr  = '0;
    i_reg_wdata = '0;
    i_mem_ack   = 1'b0;
    i_mem_rdata = '0;
    lcg_state   = 32'd57273;
    checks      = 0;
    errors      = 0;
    cycles      = 0;

    $readmemh("sim/dma_stim.txt", stim);

    // every NDTR write adds items, each item is two beats of a few cycles
    items = 0;
    for (int i = 0; i < STIM_OPS; i++) begin
        if (stim[3*i] == 32'h0 && stim[3*i+1] < dma_reg_pkg::ADDR_ISR &&
            stim[3*i+1][3:0] == dma_reg_pkg::OFF_NDTR) begin
            items += int'(stim[3*i+2][dma_bus_pkg::CNT_W-1:0]);
        end
    end
    cycle_limit = 20 * 4 * items + 2000;

    repeat (3) @(posedge i_hclk);
    i_rst_n <= 1'b1;

    idx     = 0;
    running = 1'b1;
    while (running) begin
        op   = stim[3*idx];
        addr = stim[3*idx+1];
        data = stim[3*idx+2];
        case (op)
            32'h0: host_access(1'b1, addr[7:0], data, rdata);
            32'h1: begin
                host_access(1'b0, addr[7:0], 32'h0, rdata);
                check_value($sformatf("reg_%02h", addr[7:0]), data, rdata);
                // streams under test all run with tcie, so the lines mirror ISR
                if (addr[7:0] == dma_reg_pkg::ADDR_ISR) begin
                    check_value("o_interrupt", data, 32'(o_interrupt));
                end
            end
            32'h2: mem[addr] = data;
            32'h3: begin
                host_access(1'b1, addr[7:0], data, rdata);
                wait_interrupt(addr[5:4]);
            end
            32'h4: check_value($sformatf("mem_%08h", addr), data, mem_read(addr));
            32'hF: running = 1'b0;
            default: begin
                errors++;
                $display("stim file holds an unknown operation %h at entry %0d", op, idx);
                running = 1'b0;
            end
        endcase
        idx++;
    end

    repeat (2) @(posedge i_hclk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: sim/dma_stim.txt
// columns: op addr data, hex. op 0 reg write, 1 reg read and expect, 2 preload mem word,
// 3 write CR then wait for the stream interrupt, 4 expect mem word, F end. blank mem = addr^a5a55a5a
// register readback on stream 2
1 40 00000000
0 20 FFFFFFF6
1 20 00000036
0 24 00000015
1 24 00000015
0 28 A5A50000
1 28 A5A50000
0 2C 0000C0DE
1 2C 0000C0DE
// single copy on stream 1
2 1000 11110000
2 1004 11110001
2 1008 11110002
2 100C 11110003
2 1010 11110004
2 1014 11110005
0 14 00000006
0 18 00001000
0 1C 00002000
3 10 0000000F
4 2000 11110000
4 2004 11110001
4 2008 11110002
4 200C 11110003
4 2010 11110004
4 2014 11110005
1 14 00000000
1 10 0000000E
1 40 00000002
// clear
0 44 00000002
1 40 00000000
// priority, stream 0 low with blank source, stream 3 high
2 5000 33330000
2 5004 33330001
0 04 00000008
0 08 00003000
0 0C 00004000
0 34 00000002
0 38 00005000
0 3C 00006000
0 00 0000000F
3 30 0000003F
1 40 00000008
3 00 0000000F
1 40 00000009
4 4000 A5A56A5A
4 4004 A5A56A5E
4 4008 A5A56A52
4 400C A5A56A56
4 4010 A5A56A4A
4 4014 A5A56A4E
4 4018 A5A56A42
4 401C A5A56A46
4 6000 33330000
4 6004 33330001
0 44 00000009
// locked SAR and fixed destination on stream 1
2 7000 55550000
2 7004 55550001
2 7008 55550002
2 700C 55550003
2 8004 DEADDEAD
0 14 00000004
0 18 00007000
0 1C 00008000
0 10 00000007
0 18 00009999
1 18 00007000
3 10 00000007
4 8000 55550003
4 8004 DEADDEAD
0 44 00000002
// zero count on stream 2
2 9000 12345678
0 24 00000000
0 2C 00009000
3 20 00000003
1 40 00000004
4 9000 12345678
F 0 0

// File: sources.f
hdl/dma_bus_pkg.sv
hdl/dma_reg_pkg.sv
hdl/dma_regs.sv
hdl/dma_stream.sv
hdl/dma_bus_arbiter.sv
hdl/dma_top.sv
sim/tb_dma_top.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
TOP        ?= tb_dma_top
RTL_TOP    ?= dma_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
